// File: rtl/dma_pkg.sv
`default_nettype none

package dma_pkg;

	// ----------------------------
	// Widths
	// ----------------------------
	localparam int addr_w = 16; // Word addresses and word counts
	localparam int data_w = 16; // One data word

	// ----------------------------
	// Enums
	// ----------------------------
	typedef enum logic
	{
		dir_write = 1'b0, // Device to memory
		dir_read  = 1'b1  // Memory to device
	} dma_dir_e;

	typedef enum logic [1:0]
	{
		st_done      = 2'd0,
		st_bus_error = 2'd1, // Error response from memory
		st_empty     = 2'd2  // Zero word count, no bus access
	} dma_status_e;

	// ----------------------------
	// Structs
	// ----------------------------
	// Transfer request from the device, start address in bytes
	typedef struct packed
	{
		dma_dir_e          dir;
		logic [addr_w:0]   start_addr;
		logic [addr_w-1:0] num_words;
	} dma_request_t;

	typedef struct packed
	{
		logic [addr_w-1:0] addr;  // Word address
		logic              we;    // Whole word write
		logic [data_w-1:0] wdata;
	} mem_cmd_t;

	typedef struct packed
	{
		logic [data_w-1:0] rdata;
		logic              err;   // dma_resp seen with dma_ready
	} mem_rsp_t;

endpackage

`default_nettype wire

// File: rtl/dma_dev_port.sv
`timescale 1ns/10ps
`default_nettype none

module dma_dev_port (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  rqst,
	input  dma_pkg::dma_request_t request,
	input  logic                  dev_ack,
	input  logic                  dev_want,
	input  logic                  busy,
	output logic                  cmd_ack,
	output logic                  start,
	output dma_pkg::dma_request_t req_q,
	output logic                  dma_ack,
	output logic                  dev_take
);
	import dma_pkg::*;

	logic accept; // New command taken this cycle

	// ----------------------------
	// Command handshake
	// ----------------------------
	// Only sampled while idle and with the previous handshake closed
	assign accept = rqst && !cmd_ack && !busy;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cmd_ack <= 1'b0;
			start   <= 1'b0;
		end
		else
		begin
			start <= accept; // One cycle, same edge as the latch
			if (accept)
				cmd_ack <= 1'b1;
			else if (!rqst)
				cmd_ack <= 1'b0; // Device released rqst
		end
	end

	// Request latch, byte address turned into word address
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			req_q.dir        <= request.dir;
			req_q.start_addr <= {1'b0, request.start_addr[addr_w:1]}; // Drop bit 0
			req_q.num_words  <= request.num_words;
		end
	end

	// ----------------------------
	// Word strobes
	// ----------------------------
	assign dma_ack  = dev_want && dev_ack; // Only while the device is ready
	assign dev_take = dma_ack;             // Same strobe toward the sequencer

endmodule

`default_nettype wire

// File: rtl/dma_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module dma_fifo #(
	parameter int fifo_depth_log2 = 3
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      clear,
	input  logic                      push,
	input  logic                      pop,
	input  logic [dma_pkg::data_w-1:0] wdata,
	output logic [dma_pkg::data_w-1:0] rdata,
	output logic                      full,
	output logic                      empty
);
	import dma_pkg::*;

	localparam int depth = 1 << fifo_depth_log2;

	logic [data_w-1:0]          mem [depth];
	logic [fifo_depth_log2-1:0] wr_ptr;
	logic [fifo_depth_log2-1:0] rd_ptr;
	logic [fifo_depth_log2:0]   count; // One extra bit for full
	logic                       do_push;
	logic                       do_pop;

	assign do_push = push && !full;  // Overflow ignored
	assign do_pop  = pop && !empty;  // Underflow ignored

	// Storage
	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else if (clear)
		begin
			wr_ptr <= '0; // New transfer starts empty
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	assign rdata = mem[rd_ptr];              // Head word, valid when not empty
	assign full  = count[fifo_depth_log2];   // Count reached depth
	assign empty = (count == '0);

endmodule

`default_nettype wire

// File: rtl/dma_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module dma_sequencer #(
	parameter int fifo_depth_log2 = 3
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       start,
	input  dma_pkg::dma_request_t      req_q,
	input  logic                       dev_take,
	input  logic [dma_pkg::data_w-1:0] dev_in,
	input  logic                       full,
	input  logic                       empty,
	input  logic [dma_pkg::data_w-1:0] rdata,
	input  logic                       mem_ack,
	input  dma_pkg::mem_rsp_t          mem_rsp,
	output logic                       busy,
	output logic                       dev_want,
	output logic                       push,
	output logic                       pop,
	output logic                       clear,
	output logic [dma_pkg::data_w-1:0] fifo_wdata,
	output logic                       mem_req,
	output dma_pkg::mem_cmd_t          mem_cmd,
	output logic                       end_flag,
	output dma_pkg::dma_status_e       status
);
	import dma_pkg::*;

	typedef enum logic [2:0]
	{
		s_idle,
		s_check,  // Zero count test
		s_fill,   // Into the FIFO
		s_drain,  // Out of the FIFO
		s_finish  // End pulse
	} seq_state_e;

	seq_state_e               state;
	logic [addr_w-1:0]        fill_cnt;  // Words left to fill, whole transfer
	logic [fifo_depth_log2:0] drain_cnt; // Words left to drain, this round
	logic [addr_w-1:0]        addr_q;    // Next memory word address
	dma_status_e              status_q;

	logic is_read;
	logic fill_open;  // Fill side may move a word
	logic drain_open; // Drain side may move a word
	logic mem_want;
	logic mem_done;   // Bus port answered our request
	logic mem_ok;
	logic mem_err;
	logic fill_end;
	logic drain_end;

	// ----------------------------
	// Word movement
	// ----------------------------
	assign is_read    = (req_q.dir == dir_read);
	assign fill_open  = (state == s_fill) && !full && (fill_cnt != '0);
	assign drain_open = (state == s_drain) && !empty;

	// Memory side and device side swap roles with the direction
	assign dev_want = is_read ? drain_open : fill_open;
	assign mem_want = is_read ? fill_open : drain_open;

	// mem_ack stays high one cycle after mem_req drops, so qualify it
	assign mem_done = mem_req && mem_ack;
	assign mem_ok   = mem_done && !mem_rsp.err;
	assign mem_err  = mem_done && mem_rsp.err;

	assign push = (state == s_fill) && (is_read ? mem_ok : dev_take);
	assign pop  = (state == s_drain) && (is_read ? dev_take : mem_ok);

	assign fifo_wdata = is_read ? mem_rsp.rdata : dev_in;

	// Head word and address only change after the ack, so the command stays stable
	assign mem_cmd = '{addr: addr_q, we: !is_read, wdata: rdata};

	assign fill_end  = full || (fill_cnt == '0);
	assign drain_end = (drain_cnt == '0); // FIFO empty at the same time

	// ----------------------------
	// Status and control outputs
	// ----------------------------
	assign clear    = start && (state == s_idle);
	assign busy     = (state != s_idle);
	assign end_flag = (state == s_finish);
	assign status   = status_q;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state     <= s_idle;
			fill_cnt  <= '0;
			drain_cnt <= '0;
			addr_q    <= '0;
			status_q  <= st_done;
			mem_req   <= 1'b0;
		end
		else
		begin
			// Four-phase request toward the bus port
			if (mem_ack)
				mem_req <= 1'b0;
			else if (mem_want && !mem_req)
				mem_req <= 1'b1; // Previous ack already low

			// Counters, push and pop never in the same cycle
			if (push)
			begin
				fill_cnt  <= fill_cnt - 1'b1;
				drain_cnt <= drain_cnt + 1'b1;
			end
			if (pop)
				drain_cnt <= drain_cnt - 1'b1;
			if (mem_ok)
				addr_q <= addr_q + 1'b1; // Wraps at addr_w

			case (state)
				s_idle:
				begin
					if (start)
					begin
						fill_cnt  <= req_q.num_words;
						drain_cnt <= '0;
						addr_q    <= req_q.start_addr[addr_w-1:0];
						state     <= s_check;
					end
				end
				s_check:
				begin
					if (fill_cnt == '0)
					begin
						status_q <= st_empty; // Nothing to move
						state    <= s_finish;
					end
					else
					begin
						status_q <= st_done;
						state    <= s_fill;
					end
				end
				s_fill:
				begin
					if (mem_err)
					begin
						status_q <= st_bus_error;
						state    <= s_finish;
					end
					else if (fill_end)
						state <= s_drain; // Chunk complete
				end
				s_drain:
				begin
					if (mem_err)
					begin
						status_q <= st_bus_error;
						state    <= s_finish;
					end
					else if (drain_end)
						state <= (fill_cnt == '0) ? s_finish : s_fill; // Next round
				end
				s_finish:
					state <= s_idle;
				default:
					state <= s_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/dma_mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module dma_mem_port (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       mem_req,
	input  dma_pkg::mem_cmd_t          mem_cmd,
	input  logic [dma_pkg::data_w-1:0] dma_in,
	input  logic                       dma_ready,
	input  logic                       dma_resp,
	output logic                       mem_ack,
	output dma_pkg::mem_rsp_t          mem_rsp,
	output logic                       dma_en,
	output logic                       dma_we,
	output logic [dma_pkg::addr_w-1:0] dma_addr,
	output logic [dma_pkg::data_w-1:0] dma_out
);
	import dma_pkg::*;

	typedef enum logic [1:0]
	{
		b_idle,
		b_access, // Bus driven, waiting for dma_ready
		b_ack     // Response held until mem_req drops
	} bus_state_e;

	bus_state_e state;
	mem_cmd_t   cmd_q;
	mem_rsp_t   rsp_q;

	// ----------------------------
	// Handshake FSM
	// ----------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= b_idle;
		else
		begin
			case (state)
				b_idle:
				begin
					if (mem_req)
						state <= b_access; // dma_en next cycle
				end
				b_access:
				begin
					if (dma_ready)
						state <= b_ack;
				end
				b_ack:
				begin
					if (!mem_req)
						state <= b_idle; // Sequencer saw the ack
				end
				default:
					state <= b_idle;
			endcase
		end
	end

	// Command and response registers
	always_ff @(posedge clk)
	begin
		if (state == b_idle && mem_req)
			cmd_q <= mem_cmd;
		if (state == b_access && dma_ready)
			rsp_q <= '{rdata: dma_in, err: dma_resp};
	end

	// ----------------------------
	// Bus outputs
	// ----------------------------
	assign dma_en   = (state == b_access); // Held until dma_ready
	assign dma_we   = dma_en && cmd_q.we;
	assign dma_addr = cmd_q.addr;
	assign dma_out  = cmd_q.wdata;

	assign mem_ack = (state == b_ack);
	assign mem_rsp = rsp_q;

endmodule

`default_nettype wire

// File: rtl/dma_controller.sv
`timescale 1ns/10ps
`default_nettype none

module dma_controller #(
	parameter int fifo_depth_log2 = 3 // 8 words per chunk
) (
	input  logic                       clk,
	input  logic                       reset,
	// Device side
	input  logic                       rqst,
	input  dma_pkg::dma_request_t      request,
	output logic                       cmd_ack,
	input  logic                       dev_ack,
	input  logic [dma_pkg::data_w-1:0] dev_in,
	output logic [dma_pkg::data_w-1:0] dev_out,
	output logic                       dma_ack,
	output logic                       end_flag,
	output dma_pkg::dma_status_e       status,
	// Memory bus side
	input  logic [dma_pkg::data_w-1:0] dma_in,
	input  logic                       dma_ready,
	input  logic                       dma_resp,
	output logic [dma_pkg::addr_w-1:0] dma_addr,
	output logic [dma_pkg::data_w-1:0] dma_out,
	output logic                       dma_en,
	output logic                       dma_we
);
	import dma_pkg::*;

	dma_request_t      req_q;
	logic              start;
	logic              busy;
	logic              dev_want;
	logic              dev_take;
	logic              push;
	logic              pop;
	logic              clear;
	logic              full;
	logic              empty;
	logic [data_w-1:0] fifo_wdata;
	logic [data_w-1:0] fifo_rdata;
	logic              mem_req;
	logic              mem_ack;
	mem_cmd_t          mem_cmd;
	mem_rsp_t          mem_rsp;

	assign dev_out = fifo_rdata; // FIFO head straight to the device

	dma_dev_port dma_dev_port_inst (
		.clk(clk), .reset(reset), .rqst(rqst), .request(request),
		.dev_ack(dev_ack), .dev_want(dev_want), .busy(busy),
		.cmd_ack(cmd_ack), .start(start), .req_q(req_q),
		.dma_ack(dma_ack), .dev_take(dev_take)
	);

	dma_sequencer #(.fifo_depth_log2(fifo_depth_log2)) dma_sequencer_inst (
		.clk(clk), .reset(reset), .start(start), .req_q(req_q),
		.dev_take(dev_take), .dev_in(dev_in), .full(full), .empty(empty),
		.rdata(fifo_rdata), .mem_ack(mem_ack), .mem_rsp(mem_rsp),
		.busy(busy), .dev_want(dev_want), .push(push), .pop(pop), .clear(clear),
		.fifo_wdata(fifo_wdata), .mem_req(mem_req), .mem_cmd(mem_cmd),
		.end_flag(end_flag), .status(status)
	);

	dma_fifo #(.fifo_depth_log2(fifo_depth_log2)) dma_fifo_inst (
		.clk(clk), .reset(reset), .clear(clear), .push(push), .pop(pop),
		.wdata(fifo_wdata), .rdata(fifo_rdata), .full(full), .empty(empty)
	);

	dma_mem_port dma_mem_port_inst (
		.clk(clk), .reset(reset), .mem_req(mem_req), .mem_cmd(mem_cmd),
		.dma_in(dma_in), .dma_ready(dma_ready), .dma_resp(dma_resp),
		.mem_ack(mem_ack), .mem_rsp(mem_rsp), .dma_en(dma_en), .dma_we(dma_we),
		.dma_addr(dma_addr), .dma_out(dma_out)
	);

endmodule

`default_nettype wire

// File: verification/dma_tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module dma_tb_clock #(
	parameter int reset_cycles = 8
) (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	initial
	begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0; // Released on a rising edge
	end

endmodule

`default_nettype wire

// File: verification/dma_tb_mem.sv
`timescale 1ns/10ps
`default_nettype none

module dma_tb_mem #(
	parameter logic [31:0] seed_init = 32'h40c0b687
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       wait_en,  // Random wait states on
	input  logic                       err_en,
	input  logic [dma_pkg::addr_w-1:0] err_addr, // Answered with dma_resp
	input  logic                       dma_en,
	input  logic                       dma_we,
	input  logic [dma_pkg::addr_w-1:0] dma_addr,
	input  logic [dma_pkg::data_w-1:0] dma_out,
	output logic [dma_pkg::data_w-1:0] dma_in,
	output logic                       dma_ready,
	output logic                       dma_resp
);
	import dma_pkg::*;

	logic [data_w-1:0] mem [1 << addr_w];
	logic [1:0]        wait_cnt; // Cycles left before dma_ready
	logic              hit;      // Access completes this cycle
	logic              bad;
	integer            seed;

	// Fill pattern, a rotation of the whole address
	initial
	begin
		int a;
		seed = seed_init;
		for (a = 0; a < (1 << addr_w); a++)
			mem[a] = {a[3:0], a[15:4]} ^ 16'hc3a5;
	end

	assign hit = dma_en && !dma_ready && (wait_cnt == '0);
	assign bad = err_en && (dma_addr == err_addr);

	// ----------------------------
	// Bus response
	// ----------------------------
	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			dma_ready <= 1'b0;
			dma_resp  <= 1'b0;
			dma_in    <= '0;
			wait_cnt  <= '0;
		end
		else
		begin
			dma_ready <= hit; // One cycle only
			dma_resp  <= hit && bad;
			if (hit)
			begin
				dma_in   <= mem[dma_addr];
				wait_cnt <= wait_en ? 2'($random(seed)) : 2'd0; // For the next access
			end
			else if (dma_en && !dma_ready)
				wait_cnt <= wait_cnt - 1'b1;
		end
	end

	// Erroring address is never written
	always @(posedge clk)
	begin
		if (hit && dma_we && !bad)
			mem[dma_addr] <= dma_out;
	end

endmodule

`default_nettype wire

// File: verification/dma_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dma_tb;
	import dma_pkg::*;

	localparam int fifo_depth_log2 = 3;
	localparam int depth           = 1 << fifo_depth_log2;
	localparam int max_words       = 64; // Device word buffer

	logic              clk;
	logic              reset;
	logic              rqst;
	dma_request_t      request;
	logic              cmd_ack;
	logic              dev_ack;
	logic [data_w-1:0] dev_in;
	logic [data_w-1:0] dev_out;
	logic              dma_ack;
	logic              end_flag;
	dma_status_e       status;
	logic [data_w-1:0] dma_in;
	logic [data_w-1:0] dma_out;
	logic [addr_w-1:0] dma_addr;
	logic              dma_ready;
	logic              dma_resp;
	logic              dma_en;
	logic              dma_we;
	logic              wait_en;
	logic              err_en;
	logic [addr_w-1:0] err_addr;

	integer seed = 32'h40c0b687;
	integer ack_seed;      // Drawn from seed, device ack only
	int     errors;
	int     checks;
	bit     timed_out;

	// Device model and reference state
	logic              rand_ack;
	dma_dir_e          dev_dir;
	logic [data_w-1:0] tx [max_words]; // Words the device supplies in a write
	int                tx_idx;
	logic [data_w-1:0] ref_mem [1 << addr_w];

	// Monitor records
	logic [data_w-1:0] rx_q [$];       // Words seen by the device in a read
	logic [addr_w-1:0] acc_addr_q [$];
	logic              acc_we_q [$];
	int                en_cycles;
	int                end_cnt;
	dma_status_e       end_status;
	int                cyc;
	int                rqst_cyc;
	int                end_cyc;
	logic              rqst_d;
	logic              prev_en;
	logic              prev_we;
	logic [addr_w-1:0] prev_addr;
	logic [data_w-1:0] prev_out;

	dma_tb_clock dma_tb_clock_inst (.clk(clk), .reset(reset));

	dma_tb_mem dma_tb_mem_inst (
		.clk(clk), .reset(reset), .wait_en(wait_en), .err_en(err_en), .err_addr(err_addr),
		.dma_en(dma_en), .dma_we(dma_we), .dma_addr(dma_addr), .dma_out(dma_out),
		.dma_in(dma_in), .dma_ready(dma_ready), .dma_resp(dma_resp)
	);

	dma_controller #(.fifo_depth_log2(fifo_depth_log2)) dma_controller_inst (
		.clk(clk), .reset(reset), .rqst(rqst), .request(request), .cmd_ack(cmd_ack),
		.dev_ack(dev_ack), .dev_in(dev_in), .dev_out(dev_out), .dma_ack(dma_ack),
		.end_flag(end_flag), .status(status), .dma_in(dma_in), .dma_ready(dma_ready),
		.dma_resp(dma_resp), .dma_addr(dma_addr), .dma_out(dma_out), .dma_en(dma_en),
		.dma_we(dma_we)
	);

	// ----------------------------
	// Device model
	// ----------------------------
	always @(posedge clk)
	begin
		dev_ack <= rand_ack ? 1'($random(ack_seed)) : 1'b1;
		if (dma_ack)
			tx_idx <= tx_idx + 1; // Word taken
		dev_in <= tx[(tx_idx + dma_ack) % max_words];
	end

	// Monitor, samples only at the rising edge
	always @(posedge clk)
	begin
		cyc    <= cyc + 1;
		rqst_d <= rqst;
		if (rqst && !rqst_d)
			rqst_cyc <= cyc;
		if (end_flag)
		begin
			end_cnt    <= end_cnt + 1;
			end_status <= status; // Valid with end_flag
			end_cyc    <= cyc;
		end
		if (dma_ack && dev_dir == dir_read)
			rx_q.push_back(dev_out);
		if (dma_en)
			en_cycles <= en_cycles + 1;
		if (dma_en && dma_ready)
		begin
			acc_addr_q.push_back(dma_addr);
			acc_we_q.push_back(dma_we);
		end
		assert (!dma_ack || dev_ack)
		else
		begin
			$display("Error: time %0t, dma_ack = 1 while dev_ack = %b", $time, dev_ack);
			errors++;
		end
		// Bus command held until dma_ready, unused write data may be unknown
		assert (!(dma_en && prev_en) ||
			({dma_addr, dma_we, dma_out} === {prev_addr, prev_we, prev_out}))
		else
		begin
			$display("Error: time %0t, {dma_addr, dma_we, dma_out} = %h, held value %h",
				$time, {dma_addr, dma_we, dma_out}, {prev_addr, prev_we, prev_out});
			errors++;
		end
		prev_en   <= dma_en;
		prev_we   <= dma_we;
		prev_addr <= dma_addr;
		prev_out  <= dma_out;
	end

	// ----------------------------
	// Check and wait helpers
	// ----------------------------
	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("Error: time %0t, %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic wait_cmd_ack(input logic level);
		int n;
		n = 0;
		while (cmd_ack !== level && n < 20)
		begin
			@(posedge clk);
			n++;
		end
		if (cmd_ack !== level)
		begin
			$display("Timeout waiting for cmd_ack to reach %0b", level);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_end(input int count0, input int limit);
		int n;
		n = 0;
		while (end_cnt == count0 && n < limit)
		begin
			@(posedge clk);
			n++;
		end
		if (end_cnt == count0)
		begin
			$display("Timeout waiting for end_flag after %0d cycles", limit);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	// Four-phase command, then wait for the end pulse
	task automatic run_transfer(input dma_dir_e dir, input logic [addr_w:0] start_byte,
		input int n_words);
		int count0;
		rx_q.delete();
		acc_addr_q.delete();
		acc_we_q.delete();
		en_cycles = 0;
		count0    = end_cnt;
		dev_dir   = dir;
		tx_idx   <= 0;
		@(posedge clk);
		rqst    <= 1'b1;
		request <= '{dir: dir, start_addr: start_byte, num_words: addr_w'(n_words)};
		wait_cmd_ack(1'b1);
		rqst <= 1'b0; // Dropped even after a timeout
		if (timed_out)
			return;
		wait_cmd_ack(1'b0);
		if (timed_out)
			return;
		wait_end(count0, 4000);
	endtask

	// Whole memory against the reference copy
	task automatic check_memory;
		int a;
		int bad;
		bad = 0;
		for (a = 0; a < (1 << addr_w); a++)
			if (dma_tb_mem_inst.mem[a] !== ref_mem[a])
				bad++;
		check_val("mismatched memory words", bad, 0);
	endtask

	task automatic check_accesses(input logic [addr_w-1:0] base, input int n, input logic we);
		int i;
		check_val("bus access count", acc_addr_q.size(), n);
		for (i = 0; i < n && i < acc_addr_q.size(); i++)
		begin
			check_val("dma_addr", acc_addr_q[i], addr_w'(base + i)); // Wraps
			check_val("dma_we", acc_we_q[i], we);
		end
	endtask

	// ----------------------------
	// Tests
	// ----------------------------
	task automatic read_test(input int n_words, input logic waits);
		logic [addr_w:0]   start_byte;
		logic [addr_w-1:0] base;
		int                i;
		if (timed_out)
			return;
		start_byte = 17'($random(seed)); // Odd byte addresses too
		base       = start_byte[addr_w:1];
		wait_en   <= waits;
		rand_ack  <= waits;
		run_transfer(dir_read, start_byte, n_words);
		if (timed_out)
			return;
		check_val("status", end_status, st_done);
		check_val("device word count", rx_q.size(), n_words);
		for (i = 0; i < n_words && i < rx_q.size(); i++)
			check_val("dev_out", rx_q[i], ref_mem[addr_w'(base + i)]);
		check_accesses(base, n_words, 1'b0);
		check_memory(); // Read leaves memory alone
	endtask

	// err_at below zero means no bus error
	task automatic write_test(input int n_words, input int err_at);
		logic [addr_w:0]   start_byte;
		logic [addr_w-1:0] base;
		int                i;
		int                n_ref;
		if (timed_out)
			return;
		start_byte = 17'($random(seed));
		base       = start_byte[addr_w:1];
		for (i = 0; i < max_words; i++)
			tx[i] = 16'($random(seed));
		rand_ack <= 1'b1;
		wait_en  <= (err_at >= 0);
		err_en   <= (err_at >= 0);
		err_addr <= addr_w'(base + err_at);
		run_transfer(dir_write, start_byte, n_words);
		if (timed_out)
			return;
		n_ref = (err_at >= 0) ? err_at : n_words; // Words that reach memory
		for (i = 0; i < n_ref; i++)
			ref_mem[addr_w'(base + i)] = tx[i];
		check_val("status", end_status, (err_at >= 0) ? st_bus_error : st_done);
		check_accesses(base, (err_at >= 0) ? err_at + 1 : n_words, 1'b1); // Stops at error
		check_memory();
		err_en <= 1'b0;
	endtask

	task automatic zero_test;
		if (timed_out)
			return;
		wait_en  <= 1'b0;
		rand_ack <= 1'b1;
		run_transfer(dir_read, 17'($random(seed)), 0);
		if (timed_out)
			return;
		check_val("status", end_status, st_empty);
		check_val("dma_en cycles", en_cycles, 0);
		check_val("end_flag delay", end_cyc - rqst_cyc, 3);
		check_memory();
	endtask

	initial
	begin
		int a;
		int n;
		rqst       = 1'b0;
		request    = '0;
		dev_ack    = 1'b0;
		dev_in     = '0;
		wait_en    = 1'b0;
		err_en     = 1'b0;
		err_addr   = '0;
		rand_ack   = 1'b0;
		dev_dir    = dir_read;
		tx_idx     = 0;
		errors     = 0;
		checks     = 0;
		timed_out  = 1'b0;
		cyc        = 0;
		rqst_cyc   = 0;
		end_cyc    = 0;
		end_cnt    = 0;
		en_cycles  = 0;
		end_status = st_done;
		rqst_d     = 1'b0;
		prev_en    = 1'b0;
		prev_we    = 1'b0;
		prev_addr  = '0;
		prev_out   = '0;
		ack_seed   = $random(seed);

		n = 0;
		while (reset !== 1'b0 && n < 50)
		begin
			@(posedge clk);
			n++;
		end
		if (reset !== 1'b0)
		begin
			$display("Timeout waiting for reset release");
			errors++;
			timed_out = 1'b1;
		end
		for (a = 0; a < (1 << addr_w); a++)
			ref_mem[a] = dma_tb_mem_inst.mem[a];
		@(posedge clk);

		// Idle outputs after reset
		check_val("cmd_ack", cmd_ack, 0);
		check_val("dma_ack", dma_ack, 0);
		check_val("dma_en", dma_en, 0);
		check_val("dma_we", dma_we, 0);
		check_val("end_flag", end_flag, 0);

		read_test(1 + $unsigned($random(seed)) % (depth - 1), 1'b0);        // Below one chunk
		write_test(depth + 1 + $unsigned($random(seed)) % (2 * depth), -1); // Several chunks
		read_test(2 * depth + $unsigned($random(seed)) % (2 * depth), 1'b1); // With wait states
		write_test(20, 2 + $unsigned($random(seed)) % 16);                  // Bus error inside
		zero_test();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && !timed_out)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
rtl/dma_pkg.sv
rtl/dma_dev_port.sv
rtl/dma_fifo.sv
rtl/dma_sequencer.sv
rtl/dma_mem_port.sv
rtl/dma_controller.sv
verification/dma_tb_clock.sv
verification/dma_tb_mem.sv
verification/dma_tb.sv
